// ==== pcie_trans.f ====
logic/pcie_trans_pkg.sv
logic/pcie_fifo.sv
logic/vc_router.sv
logic/vc_arbiter.sv
logic/dest_demux.sv
logic/trans_control.sv
logic/pcie_trans.sv
dv/pcie_trans_properties.sv
dv/pcie_trans_tb.sv

// ==== dv/pcie_trans_tb.sv ====
`timescale 1ns/100ps
//======================================
// Testbench for the transaction switch
// routing, back-pressure, init, overflow
//======================================
module pcie_trans_tb import pcie_trans_pkg::*; ();

	localparam int CLK_PERIOD  = 4;
	localparam int ROUTE_WORDS = 48;
	localparam int RAND_WORDS  = 64;
	// Cycle cap for fill and overflow loops
	localparam int LOOP_LIMIT  = 256;
	localparam int TEST_WORDS  = 3 * ROUTE_WORDS + RAND_WORDS + 2 * LOOP_LIMIT;
	localparam int MARGIN      = 500;
	// Pop drive modes
	localparam int POPS_HIGH   = 0;
	localparam int POPS_RANDOM = 1;
	localparam int POPS_LOW    = 2;

	logic       clk;
	logic       reset_L;
	logic       init;
	thresh_mf_t init_thresh_mf;
	thresh_vc_t init_thresh_vc;
	thresh_d_t  init_thresh_d;
	logic       push;
	word_t      data_in;
	logic       pop0;
	logic       pop1;
	word_t      data_out0;
	word_t      data_out1;
	logic       valid_out0;
	logic       valid_out1;
	logic       pause_mf;
	logic       active_out;
	logic       idle_out;
	logic       error_out;

	// Expected words indexed by {vc, dest}
	word_t       exp_q [4][$];
	logic [31:0] rng;
	int          pop_mode;
	bit          active_seen;

	pcie_trans dut (
		.clk(clk), .reset_L(reset_L), .init(init),
		.init_thresh_mf(init_thresh_mf), .init_thresh_vc(init_thresh_vc),
		.init_thresh_d(init_thresh_d),
		.push(push), .data_in(data_in), .pop0(pop0), .pop1(pop1),
		.data_out0(data_out0), .data_out1(data_out1),
		.valid_out0(valid_out0), .valid_out1(valid_out1),
		.pause_mf(pause_mf), .active_out(active_out),
		.idle_out(idle_out), .error_out(error_out)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#(CLK_PERIOD / 2) clk = ~clk;
		end
	end

	function automatic logic [31:0] lcg_next(input logic [31:0] state);
		return state * 32'd1103515245 + 32'd12345;
	endfunction

	task automatic next_rand(output logic [31:0] value);
		rng = lcg_next(rng);
		value = rng;
	endtask

	// Reference routing by VC bit 5 and destination bit 4
	function automatic int expected_route(input word_t w);
		return (w[VC_BIT] ? 2 : 0) + (w[DEST_BIT] ? 1 : 0);
	endfunction

	function automatic int pending_words();
		return exp_q[0].size() + exp_q[1].size() + exp_q[2].size() + exp_q[3].size();
	endfunction

	task automatic report_failure(input string msg);
		$display("%s", msg);
		$display("Simulation failed");
		$fatal(1, "Stopped at the first error");
	endtask

	// One clock and the input drive just after the edge
	task automatic step_cycle();
		logic [31:0] r;
		@(posedge clk);
		#0.5;
		push = 1'b0;
		case (pop_mode)
			POPS_HIGH: begin
				pop0 = 1'b1;
				pop1 = 1'b1;
			end
			POPS_RANDOM: begin
				next_rand(r);
				pop0 = r[28];
				pop1 = r[29];
			end
			default: begin
				pop0 = 1'b0;
				pop1 = 1'b0;
			end
		endcase
	endtask

	// Sync reset over two edges and a flushed scoreboard
	task automatic apply_reset();
		reset_L = 1'b1;
		push = 1'b0;
		for (int i = 0; i < 4; i++) begin
			exp_q[i].delete();
		end
		repeat (2) @(posedge clk);
		#0.5;
		reset_L = 1'b0;
	endtask

	// Push one random word unless pause_mf holds it back
	task automatic offer_word(input bit ignore_pause, output bit sent);
		logic [31:0] r;
		word_t       w;
		sent = 1'b0;
		if (ignore_pause || !pause_mf) begin
			next_rand(r);
			w = r[31:26];
			push = 1'b1;
			data_in = w;
			sent = 1'b1;
			// Overflow words may be dropped and stay untracked
			if (!ignore_pause) begin
				exp_q[expected_route(w)].push_back(w);
			end
		end
	endtask

	task automatic send_words(input int count, input int mode);
		int sent_total;
		bit sent;
		sent_total = 0;
		pop_mode = mode;
		while (sent_total < count) begin
			step_cycle();
			offer_word(1'b0, sent);
			if (sent) begin
				sent_total++;
			end
		end
	endtask

	// Pops run until every expected word is out
	task automatic drain_words();
		pop_mode = POPS_HIGH;
		while (pending_words() > 0) begin
			step_cycle();
		end
	endtask

	task automatic wait_idle();
		int cycles;
		cycles = 0;
		while (!idle_out && cycles < 20) begin
			step_cycle();
			cycles++;
		end
		assert (idle_out) else report_failure("idle_out did not rise with no traffic in flight");
		assert (!active_out) else
			report_failure($sformatf("Error at %0t: active_out expected 0, actual %b",
				$time, active_out));
	endtask

	task automatic check_back_pressure();
		int  high_run;
		int  cycles;
		bit  sent;
		high_run = 0;
		cycles = 0;
		pop_mode = POPS_LOW;
		// Pause must settle high once every stage backs up
		while (high_run < 16 && cycles < LOOP_LIMIT) begin
			step_cycle();
			offer_word(1'b0, sent);
			high_run = pause_mf ? high_run + 1 : 0;
			cycles++;
		end
		assert (high_run >= 16) else report_failure("pause_mf never rose with both pops held low");
		pop_mode = POPS_HIGH;
		cycles = 0;
		while (pause_mf && cycles < LOOP_LIMIT) begin
			step_cycle();
			cycles++;
		end
		assert (!pause_mf) else report_failure("pause_mf stayed high after the pops resumed");
		drain_words();
		wait_idle();
	endtask

	task automatic run_init();
		init_thresh_mf = thresh_mf_t'(2);
		init = 1'b1;
		for (int i = 0; i < 6; i++) begin
			step_cycle();
			// Flags lag the state by one register
			if (i >= 2) begin
				assert (!active_out && !idle_out) else
					report_failure("active_out or idle_out high during init");
			end
		end
		init = 1'b0;
	endtask

	task automatic force_overflow();
		int cycles;
		bit sent;
		cycles = 0;
		pop_mode = POPS_LOW;
		while (!error_out && cycles < LOOP_LIMIT) begin
			step_cycle();
			offer_word(1'b1, sent);
			cycles++;
		end
		assert (error_out) else report_failure("error_out never rose while pushing into a full FIFO");
		// ERROR only left through reset
		for (int i = 0; i < 10; i++) begin
			step_cycle();
			assert (error_out && !active_out && !idle_out) else
				report_failure("error_out fell or a status flag rose before reset");
		end
	endtask

	task automatic check_output(input bit dest, input word_t actual);
		int    idx;
		word_t expected;
		idx = (actual[VC_BIT] ? 2 : 0) + (dest ? 1 : 0);
		assert (exp_q[idx].size() > 0) else
			report_failure($sformatf("Unexpected word %h on destination %0d with nothing pending",
				actual, dest));
		expected = exp_q[idx].pop_front();
		assert (actual == expected) else
			report_failure($sformatf("Error at %0t: data_out%0d expected %h, actual %h",
				$time, dest, expected, actual));
	endtask

	// Scoreboard compare at mid-cycle
	always @(negedge clk) begin
		if (!reset_L) begin
			if (active_out) begin
				active_seen = 1'b1;
			end
			if (valid_out0) begin
				check_output(1'b0, data_out0);
			end
			if (valid_out1) begin
				check_output(1'b1, data_out1);
			end
		end
	end

	initial begin
		repeat (TEST_WORDS * 40 + MARGIN) @(posedge clk);
		report_failure("Watchdog: the run timed out before all tests finished");
	end

	initial begin
		reset_L        = 1'b1;
		init           = 1'b0;
		init_thresh_mf = thresh_mf_t'(DEF_THRESH_MF);
		init_thresh_vc = thresh_vc_t'(DEF_THRESH_VC);
		init_thresh_d  = thresh_d_t'(DEF_THRESH_D);
		push           = 1'b0;
		data_in        = '0;
		pop0           = 1'b0;
		pop1           = 1'b0;
		rng            = 32'hfac1;
		pop_mode       = POPS_HIGH;
		active_seen    = 1'b0;
		apply_reset();
		// Quiet outputs straight out of reset
		assert (!valid_out0 && !valid_out1) else report_failure("A valid output is high after reset");
		assert (!error_out) else
			report_failure($sformatf("Error at %0t: error_out expected 0, actual %b",
				$time, error_out));
		wait_idle();
		// Routing with free-running pops
		active_seen = 1'b0;
		send_words(ROUTE_WORDS, POPS_HIGH);
		drain_words();
		wait_idle();
		assert (active_seen) else report_failure("active_out never rose while words were in flight");
		// Random pops and then stalled pops
		send_words(RAND_WORDS, POPS_RANDOM);
		drain_words();
		wait_idle();
		check_back_pressure();
		run_init();
		send_words(ROUTE_WORDS, POPS_HIGH);
		drain_words();
		wait_idle();
		// Overflow and recovery through reset
		force_overflow();
		apply_reset();
		send_words(ROUTE_WORDS, POPS_HIGH);
		drain_words();
		wait_idle();
		$display("Simulation passed");
		$finish;
	end

endmodule

// ==== dv/pcie_trans_properties.sv ====
`timescale 1ns/100ps
//======================================
// FIFO flag checks, bound to pcie_fifo
//======================================
module pcie_trans_properties (
	input logic clk,
	input logic reset_L,
	input logic pop,
	input logic valid_out,
	input logic empty,
	input logic full,
	input logic error
);

	// Occupancy cannot be zero and DEPTH at once
	full_empty_excl: assert property (
		@(posedge clk) disable iff (reset_L) !(full && empty)
	) else $error("FIFO reports full and empty in the same cycle");

	// Overflow flag only clears through reset
	error_sticky: assert property (
		@(posedge clk) disable iff (reset_L) $fell(error) |-> $past(reset_L)
	) else $error("FIFO error flag fell without a reset");

	// Read data lands one cycle after its pop
	valid_after_pop: assert property (
		@(posedge clk) disable iff (reset_L) valid_out |-> $past(pop)
	) else $error("FIFO valid_out rose without a pop one cycle earlier");

endmodule

// Every FIFO instance gets its own checker
bind pcie_fifo pcie_trans_properties props (
	.clk(clk),
	.reset_L(reset_L),
	.pop(pop),
	.valid_out(valid_out),
	.empty(empty),
	.full(full),
	.error(error)
);

// ==== logic/pcie_trans.sv ====
`timescale 1ns/100ps
//======================================
// PCIe switch transaction layer top
//======================================
module pcie_trans import pcie_trans_pkg::*; (
	input  logic       clk,
	input  logic       reset_L,
	input  logic       init,
	input  thresh_mf_t init_thresh_mf,
	input  thresh_vc_t init_thresh_vc,
	input  thresh_d_t  init_thresh_d,
	input  logic       push,
	input  word_t      data_in,
	input  logic       pop0,
	input  logic       pop1,
	output word_t      data_out0,
	output word_t      data_out1,
	output logic       valid_out0,
	output logic       valid_out1,
	output logic       pause_mf,
	output logic       active_out,
	output logic       idle_out,
	output logic       error_out
);

	// Main FIFO to router
	word_t mf_data;
	logic  mf_valid;
	logic  pop_mf;

	// Router to VC FIFOs
	word_t vc_data;
	logic  push_vc0;
	logic  push_vc1;
	logic  pause_vc0;
	logic  pause_vc1;

	// VC FIFOs to arbiter
	word_t data_vc0;
	word_t data_vc1;
	logic  valid_vc0;
	logic  valid_vc1;
	logic  pop_vc0;
	logic  pop_vc1;

	// Arbiter to demux and destinations
	word_t arb_data;
	logic  arb_valid;
	word_t dest_data;
	logic  push_d0;
	logic  push_d1;
	logic  pause_d0;
	logic  pause_d1;

	// Status toward control, bit 4 main down to bit 0 D1
	logic [NUM_FIFOS-1:0] fifo_error;
	logic [NUM_FIFOS-1:0] fifo_empty;
	thresh_mf_t           thresh_mf;
	thresh_vc_t           thresh_vc;
	thresh_d_t            thresh_d;

	pcie_fifo #(.DEPTH(MF_DEPTH), .THRESH_W($bits(thresh_mf_t))) main_fifo (
		.clk(clk), .reset_L(reset_L), .push(push), .pop(pop_mf),
		.data_in(data_in), .thresh(thresh_mf),
		.data_out(mf_data), .valid_out(mf_valid), .almost_empty(),
		.pause(pause_mf), .empty(fifo_empty[4]), .full(), .error(fifo_error[4])
	);

	vc_router u_vc_router (
		.clk(clk), .reset_L(reset_L), .mf_empty(fifo_empty[4]),
		.pause_vc0(pause_vc0), .pause_vc1(pause_vc1),
		.mf_valid(mf_valid), .mf_data(mf_data), .pop_mf(pop_mf),
		.push_vc0(push_vc0), .push_vc1(push_vc1), .vc_data(vc_data)
	);

	// VC FIFOs share the data bus, the push selects
	pcie_fifo #(.DEPTH(VC_DEPTH), .THRESH_W($bits(thresh_vc_t))) vc0_fifo (
		.clk(clk), .reset_L(reset_L), .push(push_vc0), .pop(pop_vc0),
		.data_in(vc_data), .thresh(thresh_vc),
		.data_out(data_vc0), .valid_out(valid_vc0), .almost_empty(),
		.pause(pause_vc0), .empty(fifo_empty[3]), .full(), .error(fifo_error[3])
	);

	pcie_fifo #(.DEPTH(VC_DEPTH), .THRESH_W($bits(thresh_vc_t))) vc1_fifo (
		.clk(clk), .reset_L(reset_L), .push(push_vc1), .pop(pop_vc1),
		.data_in(vc_data), .thresh(thresh_vc),
		.data_out(data_vc1), .valid_out(valid_vc1), .almost_empty(),
		.pause(pause_vc1), .empty(fifo_empty[2]), .full(), .error(fifo_error[2])
	);

	vc_arbiter u_vc_arbiter (
		.clk(clk), .reset_L(reset_L),
		.empty_vc0(fifo_empty[3]), .empty_vc1(fifo_empty[2]),
		.pause_d0(pause_d0), .pause_d1(pause_d1),
		.valid_vc0(valid_vc0), .valid_vc1(valid_vc1),
		.data_vc0(data_vc0), .data_vc1(data_vc1),
		.pop_vc0(pop_vc0), .pop_vc1(pop_vc1),
		.arb_valid(arb_valid), .arb_data(arb_data)
	);

	dest_demux u_dest_demux (
		.clk(clk), .reset_L(reset_L), .arb_valid(arb_valid), .arb_data(arb_data),
		.push_d0(push_d0), .push_d1(push_d1), .dest_data(dest_data)
	);

	// Destination FIFOs drained by the external pops
	pcie_fifo #(.DEPTH(D_DEPTH), .THRESH_W($bits(thresh_d_t))) d0_fifo (
		.clk(clk), .reset_L(reset_L), .push(push_d0), .pop(pop0),
		.data_in(dest_data), .thresh(thresh_d),
		.data_out(data_out0), .valid_out(valid_out0), .almost_empty(),
		.pause(pause_d0), .empty(fifo_empty[1]), .full(), .error(fifo_error[1])
	);

	pcie_fifo #(.DEPTH(D_DEPTH), .THRESH_W($bits(thresh_d_t))) d1_fifo (
		.clk(clk), .reset_L(reset_L), .push(push_d1), .pop(pop1),
		.data_in(dest_data), .thresh(thresh_d),
		.data_out(data_out1), .valid_out(valid_out1), .almost_empty(),
		.pause(pause_d1), .empty(fifo_empty[0]), .full(), .error(fifo_error[0])
	);

	trans_control u_trans_control (
		.clk(clk), .reset_L(reset_L), .init(init),
		.init_thresh_mf(init_thresh_mf), .init_thresh_vc(init_thresh_vc),
		.init_thresh_d(init_thresh_d),
		.fifo_error(fifo_error), .fifo_empty(fifo_empty),
		.thresh_mf(thresh_mf), .thresh_vc(thresh_vc), .thresh_d(thresh_d),
		.active_out(active_out), .idle_out(idle_out), .error_out(error_out)
	);

endmodule

// ==== logic/trans_control.sv ====
`timescale 1ns/100ps
//======================================
// Control FSM, threshold registers and
// system status flags
//======================================
module trans_control import pcie_trans_pkg::*; (
	input  logic                 clk,
	input  logic                 reset_L,
	input  logic                 init,
	input  thresh_mf_t           init_thresh_mf,
	input  thresh_vc_t           init_thresh_vc,
	input  thresh_d_t            init_thresh_d,
	input  logic [NUM_FIFOS-1:0] fifo_error,
	input  logic [NUM_FIFOS-1:0] fifo_empty,
	output thresh_mf_t           thresh_mf,
	output thresh_vc_t           thresh_vc,
	output thresh_d_t            thresh_d,
	output logic                 active_out,
	output logic                 idle_out,
	output logic                 error_out
);

	ctrl_state_t state;
	ctrl_state_t state_next;
	logic        any_error;
	logic        all_empty;

	// Bit 4 main, 3..2 VCs, 1..0 destinations
	assign any_error = |fifo_error;
	assign all_empty = &fifo_empty;

	always_comb begin
		state_next = state;
		case (state)
			// Leave on the first cycle out of reset
			RESET: begin
				state_next = init ? INIT : IDLE;
			end
			// Only reset gets out of here
			ERROR: begin
				state_next = ERROR;
			end
			// INIT, IDLE and ACTIVE share one priority order
			default: begin
				if (any_error) begin
					state_next = ERROR;
				end else if (init) begin
					state_next = INIT;
				end else if (all_empty) begin
					state_next = IDLE;
				end else begin
					state_next = ACTIVE;
				end
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset_L) begin
			state      <= RESET;
			thresh_mf  <= thresh_mf_t'(DEF_THRESH_MF);
			thresh_vc  <= thresh_vc_t'(DEF_THRESH_VC);
			thresh_d   <= thresh_d_t'(DEF_THRESH_D);
			active_out <= 1'b0;
			idle_out   <= 1'b0;
			error_out  <= 1'b0;
		end else begin
			state <= state_next;
			// Threshold load window
			if (state == INIT) begin
				thresh_mf <= init_thresh_mf;
				thresh_vc <= init_thresh_vc;
				thresh_d  <= init_thresh_d;
			end
			// Registered state decodes
			active_out <= (state == ACTIVE);
			idle_out   <= (state == IDLE);
			error_out  <= (state == ERROR);
		end
	end

endmodule

// ==== logic/dest_demux.sv ====
`timescale 1ns/100ps
//======================================
// Destination demux, one register stage
//======================================
module dest_demux import pcie_trans_pkg::*; (
	input  logic  clk,
	input  logic  reset_L,
	input  logic  arb_valid,
	input  word_t arb_data,
	output logic  push_d0,
	output logic  push_d1,
	output word_t dest_data
);

	// Payload register, loaded with each arbitrated word
	always_ff @(posedge clk) begin
		if (arb_valid) begin
			dest_data <= arb_data;
		end
	end

	// Bit 4 picks the destination
	// Strobes last exactly one cycle per word
	always_ff @(posedge clk) begin
		if (reset_L) begin
			push_d0 <= 1'b0;
			push_d1 <= 1'b0;
		end else begin
			push_d0 <= arb_valid && !arb_data[DEST_BIT];
			push_d1 <= arb_valid && arb_data[DEST_BIT];
		end
	end

endmodule

// ==== logic/vc_arbiter.sv ====
`timescale 1ns/100ps
//======================================
// Fixed priority VC arbiter, VC0 first
//======================================
module vc_arbiter import pcie_trans_pkg::*; (
	input  logic  clk,
	input  logic  reset_L,
	input  logic  empty_vc0,
	input  logic  empty_vc1,
	input  logic  pause_d0,
	input  logic  pause_d1,
	input  logic  valid_vc0,
	input  logic  valid_vc1,
	input  word_t data_vc0,
	input  word_t data_vc1,
	output logic  pop_vc0,
	output logic  pop_vc1,
	output logic  arb_valid,
	output word_t arb_data
);

	logic       pause_q;
	// Pops issued two and three cycles back
	logic [1:0] pop_hist;
	logic       pop_busy;
	logic       pop0_next;
	logic       pop1_next;

	// Combined destination pause, sampled every cycle
	always_ff @(posedge clk) begin
		if (reset_L) begin
			pause_q <= 1'b0;
		end else begin
			pause_q <= pause_d0 || pause_d1;
		end
	end

	// Words still in the pipe are not yet in the destination counts
	// Spacing the pops keeps them within the room above the pause level
	assign pop_busy = pop_vc0 || pop_vc1 || (|pop_hist);

	// VC0 wins whenever it holds data
	assign pop0_next = !pause_q && !pop_busy && !empty_vc0;
	assign pop1_next = !pause_q && !pop_busy && empty_vc0 && !empty_vc1;

	// Pop strobes one cycle after the decision
	always_ff @(posedge clk) begin
		if (reset_L) begin
			pop_vc0  <= 1'b0;
			pop_vc1  <= 1'b0;
			pop_hist <= '0;
		end else begin
			pop_vc0  <= pop0_next;
			pop_vc1  <= pop1_next;
			pop_hist <= {pop_hist[0], pop_vc0 || pop_vc1};
		end
	end

	// At most one VC returns data in a cycle
	assign arb_valid = valid_vc0 || valid_vc1;
	assign arb_data  = valid_vc0 ? data_vc0 : data_vc1;

endmodule

// ==== logic/vc_router.sv ====
`timescale 1ns/100ps
//======================================
// Main FIFO drain and VC steering
//======================================
module vc_router import pcie_trans_pkg::*; (
	input  logic  clk,
	input  logic  reset_L,
	input  logic  mf_empty,
	input  logic  pause_vc0,
	input  logic  pause_vc1,
	input  logic  mf_valid,
	input  word_t mf_data,
	output logic  pop_mf,
	output logic  push_vc0,
	output logic  push_vc1,
	output word_t vc_data
);

	// Purely combinational stage

	// Drain main FIFO while both VCs have room
	// Either VC pause holds everything back
	assign pop_mf = !mf_empty && !pause_vc0 && !pause_vc1;

	// Bit 5 picks the channel
	assign push_vc0 = mf_valid && !mf_data[VC_BIT];
	assign push_vc1 = mf_valid && mf_data[VC_BIT];

	// Same word to both VC FIFOs, the push decides
	assign vc_data = mf_data;

endmodule

// ==== logic/pcie_fifo.sv ====
`timescale 1ns/100ps
//======================================
// Circular buffer FIFO with threshold
// pause, almost-empty and overflow flags
//======================================
module pcie_fifo import pcie_trans_pkg::*; #(
	parameter int DEPTH    = MF_DEPTH,
	parameter int THRESH_W = $bits(thresh_mf_t)
) (
	input  logic                clk,
	input  logic                reset_L,
	input  logic                push,
	input  logic                pop,
	input  word_t               data_in,
	input  logic [THRESH_W-1:0] thresh,
	output word_t               data_out,
	output logic                valid_out,
	output logic                almost_empty,
	output logic                pause,
	output logic                empty,
	output logic                full,
	output logic                error
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	// One extra bit so a full count fits
	localparam int CNT_W = $clog2(DEPTH + 1);

	word_t            mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic [CNT_W-1:0] pause_level;
	logic             do_push;
	logic             do_pop;
	logic             overflow;

	// Pointer advance with wrap at DEPTH
	function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
		if (ptr == PTR_W'(DEPTH - 1)) begin
			return '0;
		end
		return ptr + 1'b1;
	endfunction

	// Pop on empty is ignored
	assign do_pop   = pop && !empty;
	// A full FIFO still takes a word when one leaves in the same cycle
	assign do_push  = push && (!full || do_pop);
	// Rejected push means the word is lost
	assign overflow = push && !do_push;

	// Storage
	always_ff @(posedge clk) begin
		if (do_push) begin
			mem[wr_ptr] <= data_in;
		end
	end

	// Read data lands one cycle after pop
	always_ff @(posedge clk) begin
		if (do_pop) begin
			data_out <= mem[rd_ptr];
		end
	end

	always_ff @(posedge clk) begin
		if (reset_L) begin
			wr_ptr    <= '0;
			rd_ptr    <= '0;
			count     <= '0;
			valid_out <= 1'b0;
			error     <= 1'b0;
		end else begin
			valid_out <= do_pop;
			if (do_push) begin
				wr_ptr <= next_ptr(wr_ptr);
			end
			if (do_pop) begin
				rd_ptr <= next_ptr(rd_ptr);
			end
			// Occupancy tracks net flow
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
			// Sticky until reset
			if (overflow) begin
				error <= 1'b1;
			end
		end
	end

	// Pause once free space drops to the threshold
	assign pause_level  = CNT_W'(DEPTH) - CNT_W'(thresh);
	assign pause        = (count >= pause_level);
	assign almost_empty = (count <= CNT_W'(thresh));
	assign empty        = (count == '0);
	assign full         = (count == CNT_W'(DEPTH));

endmodule

// ==== logic/pcie_trans_pkg.sv ====
//======================================
// Shared types and constants for the
// PCIe transaction switch
//======================================
package pcie_trans_pkg;

	// Word layout
	localparam int WORD_W   = 6;
	// Virtual channel select
	localparam int VC_BIT   = 5;
	// Destination select
	localparam int DEST_BIT = 4;

	// FIFO depths
	localparam int MF_DEPTH = 4;
	localparam int VC_DEPTH = 16;
	localparam int D_DEPTH  = 4;

	// Main, VC0, VC1, D0, D1
	localparam int NUM_FIFOS = 5;

	// Thresholds loaded on reset
	localparam int DEF_THRESH_MF = 1;
	localparam int DEF_THRESH_VC = 4;
	localparam int DEF_THRESH_D  = 1;

	typedef logic [WORD_W-1:0] word_t;

	// Main FIFO threshold
	typedef logic [1:0] thresh_mf_t;
	// Shared by both VC FIFOs
	typedef logic [3:0] thresh_vc_t;
	// Shared by both destination FIFOs
	typedef logic [1:0] thresh_d_t;

	typedef enum logic [2:0] {
		RESET,
		INIT,
		IDLE,
		ACTIVE,
		ERROR
	} ctrl_state_t;

endpackage
